// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - .
    files:
      - fetch_bus_pkg.sv
      - fetch_stream_pkg.sv
      - prefetch_unit.sv
      - byte_fifo.sv
      - ip_tracker.sv
      - byte_stream_reader.sv
      - fetch_frontend.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fetch_frontend.sv

// ==== byte_fifo.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module byte_fifo (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          wr_en,
    input  fetch_stream_pkg::fetch_byte_t wr_data,
    input  logic                          rd_en,
    output fetch_stream_pkg::fetch_byte_t rd_data,
    output logic                          empty,
    output logic                          nearly_full
);
    import fetch_stream_pkg::*;

    localparam int ptr_w = $clog2(`FETCH_FIFO_DEPTH);
    localparam int cnt_w = $clog2(`FETCH_FIFO_DEPTH + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`FETCH_FIFO_DEPTH - 1);
    localparam logic [cnt_w-1:0] depth = cnt_w'(`FETCH_FIFO_DEPTH);
    localparam logic [cnt_w-1:0] fill_limit =
        cnt_w'(`FETCH_FIFO_DEPTH - `FETCH_FIFO_MARGIN);

    fetch_byte_t      mem [`FETCH_FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == last_ptr) ? '0 : ptr + 1'b1;
    endfunction

    assign do_wr = wr_en && (count != depth);
    assign do_rd = rd_en && !empty;

    assign rd_data = mem[rd_ptr];
    assign empty = (count == '0);
    // Fewer than the margin left free
    assign nearly_full = (count > fill_limit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_rd)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

// ==== byte_stream_reader.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module byte_stream_reader (
    input  logic                          clk,
    input  logic                          arst_n,
    input  fetch_stream_pkg::fetch_byte_t fifo_rd_data,
    input  logic                          fifo_empty,
    output logic                          fifo_rd_en,
    output logic                          byte_consumed,
    input  logic                          opcode_rd,
    output fetch_stream_pkg::fetch_byte_t opcode_byte,
    input  logic                          immed_start,
    input  logic                          immed_is_8bit,
    output fetch_stream_pkg::fetch_word_t immediate,
    output logic                          immed_busy,
    output logic                          immed_complete
);
    import fetch_stream_pkg::*;

    reader_state_t state;
    logic          is_8bit;
    logic          opcode_pop;
    logic          immed_pop;

    assign opcode_pop = (state == rd_idle) && opcode_rd && !fifo_empty;
    assign immed_pop = ((state == rd_read_low) || (state == rd_read_high)) && !fifo_empty;

    assign fifo_rd_en = opcode_pop || immed_pop;
    assign byte_consumed = opcode_pop || immed_pop;

    assign immed_busy = (state != rd_idle);
    assign immed_complete = (state == rd_done);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= rd_idle;
            is_8bit <= 1'b0;
        end else begin
            case (state)
                rd_idle: begin
                    if (immed_start) begin
                        state <= rd_read_low;
                        is_8bit <= immed_is_8bit;
                    end
                end
                rd_read_low: begin
                    if (!fifo_empty)
                        state <= is_8bit ? rd_done : rd_read_high;
                end
                rd_read_high: begin
                    if (!fifo_empty)
                        state <= rd_done;
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

    // Little-endian immediates with 8-bit values zero-extended
    always_ff @(posedge clk) begin
        if (opcode_pop)
            opcode_byte <= fifo_rd_data;
        if (immed_pop && state == rd_read_low)
            immediate <= {8'h00, fifo_rd_data};
        if (immed_pop && state == rd_read_high)
            immediate[`FETCH_WORD_W-1:`FETCH_BYTE_W] <= fifo_rd_data;
    end

endmodule

// ==== fetch_bus_pkg.sv ====
`include "fetch_defs.svh"

package fetch_bus_pkg;

    // Physical address without bit 0
    typedef logic [`FETCH_ADDR_W-1:0] word_addr_t;

    // One word returned on the instruction bus
    typedef logic [`FETCH_WORD_W-1:0] bus_word_t;

    // Prefetcher states
    // discard waits for the ack of a fetch overtaken by a redirect
    typedef enum logic [2:0] {
        pf_idle,
        pf_fetching,
        pf_write_low,
        pf_write_high,
        pf_discard
    } prefetch_state_t;

endpackage

// ==== fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// One queue entry
`define FETCH_BYTE_W 8

// IP, CS, bus data and immediates
`define FETCH_WORD_W 16

// Physical word address, bits 19 down to 1
`define FETCH_ADDR_W 19

// Prefetch queue entries
`define FETCH_FIFO_DEPTH 6

// Free entries below which the queue reports nearly full
`define FETCH_FIFO_MARGIN 2

`endif

// ==== fetch_frontend.sv ====
`timescale 1ns/100ps

module fetch_frontend (
    input  logic                          clk,
    input  logic                          arst_n,
    input  fetch_stream_pkg::fetch_word_t cs,
    input  logic                          load_ip,
    input  fetch_stream_pkg::fetch_word_t new_ip,
    input  logic                          start_instruction,
    input  logic                          rollback,
    output fetch_stream_pkg::fetch_word_t ip,
    output fetch_bus_pkg::word_addr_t     instr_m_addr,
    output logic                          instr_m_access,
    input  logic                          instr_m_ack,
    input  fetch_bus_pkg::bus_word_t      instr_m_data_in,
    input  logic                          opcode_rd,
    output fetch_stream_pkg::fetch_byte_t opcode_byte,
    output logic                          stream_empty,
    input  logic                          immed_start,
    input  logic                          immed_is_8bit,
    output fetch_stream_pkg::fetch_word_t immediate,
    output logic                          immed_busy,
    output logic                          immed_complete
);
    import fetch_stream_pkg::*;

    logic        fifo_wr_en;
    fetch_byte_t fifo_wr_data;
    logic        fifo_rd_en;
    fetch_byte_t fifo_rd_data;
    logic        fifo_nearly_full;
    logic        byte_consumed;
    logic        redirect;
    fetch_word_t redirect_ip;

    prefetch_unit prefetch_unit_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .cs               (cs),
        .redirect         (redirect),
        .redirect_ip      (redirect_ip),
        .fifo_nearly_full (fifo_nearly_full),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data),
        .instr_m_addr     (instr_m_addr),
        .instr_m_access   (instr_m_access),
        .instr_m_ack      (instr_m_ack),
        .instr_m_data_in  (instr_m_data_in)
    );

    // Redirect drops everything queued from the old stream
    byte_fifo byte_fifo_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (redirect),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (stream_empty),
        .nearly_full (fifo_nearly_full)
    );

    ip_tracker ip_tracker_i (
        .clk               (clk),
        .arst_n            (arst_n),
        .byte_consumed     (byte_consumed),
        .load_ip           (load_ip),
        .new_ip            (new_ip),
        .start_instruction (start_instruction),
        .rollback          (rollback),
        .ip                (ip),
        .redirect          (redirect),
        .redirect_ip       (redirect_ip)
    );

    byte_stream_reader byte_stream_reader_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .fifo_rd_data   (fifo_rd_data),
        .fifo_empty     (stream_empty),
        .fifo_rd_en     (fifo_rd_en),
        .byte_consumed  (byte_consumed),
        .opcode_rd      (opcode_rd),
        .opcode_byte    (opcode_byte),
        .immed_start    (immed_start),
        .immed_is_8bit  (immed_is_8bit),
        .immediate      (immediate),
        .immed_busy     (immed_busy),
        .immed_complete (immed_complete)
    );

endmodule

// ==== fetch_stream_pkg.sv ====
`include "fetch_defs.svh"

package fetch_stream_pkg;

    // One byte of the instruction stream
    typedef logic [`FETCH_BYTE_W-1:0] fetch_byte_t;

    // IP, CS or immediate value
    typedef logic [`FETCH_WORD_W-1:0] fetch_word_t;

    // Immediate reader states
    typedef enum logic [1:0] {
        rd_idle,
        rd_read_low,
        rd_read_high,
        rd_done
    } reader_state_t;

endpackage

// ==== files.f ====
+incdir+.
fetch_bus_pkg.sv
fetch_stream_pkg.sv
prefetch_unit.sv
byte_fifo.sv
ip_tracker.sv
byte_stream_reader.sv
fetch_frontend.sv
tb_fetch_frontend.sv

// ==== ip_tracker.sv ====
`timescale 1ns/100ps

module ip_tracker (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          byte_consumed,
    input  logic                          load_ip,
    input  fetch_stream_pkg::fetch_word_t new_ip,
    input  logic                          start_instruction,
    input  logic                          rollback,
    output fetch_stream_pkg::fetch_word_t ip,
    output logic                          redirect,
    output fetch_stream_pkg::fetch_word_t redirect_ip
);
    import fetch_stream_pkg::*;

    fetch_word_t start_ip;

    // ip already holds the new value when redirect is high
    assign redirect_ip = ip;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ip <= '0;
            start_ip <= '0;
            redirect <= 1'b0;
        end else begin
            redirect <= load_ip || rollback;

            if (start_instruction)
                start_ip <= ip;

            if (load_ip)
                ip <= new_ip;
            else if (rollback)
                ip <= start_ip;
            else if (byte_consumed)
                ip <= ip + 1'b1;
        end
    end

endmodule

// ==== prefetch_unit.sv ====
`timescale 1ns/100ps
`include "fetch_defs.svh"

module prefetch_unit (
    input  logic                          clk,
    input  logic                          arst_n,
    input  fetch_stream_pkg::fetch_word_t cs,
    input  logic                          redirect,
    input  fetch_stream_pkg::fetch_word_t redirect_ip,
    input  logic                          fifo_nearly_full,
    output logic                          fifo_wr_en,
    output fetch_stream_pkg::fetch_byte_t fifo_wr_data,
    output fetch_bus_pkg::word_addr_t     instr_m_addr,
    output logic                          instr_m_access,
    input  logic                          instr_m_ack,
    input  fetch_bus_pkg::bus_word_t      instr_m_data_in
);
    import fetch_bus_pkg::*;
    import fetch_stream_pkg::*;

    prefetch_state_t        state;
    fetch_word_t            fetch_ip;
    bus_word_t              fetched_word;
    logic [`FETCH_ADDR_W:0] phys_addr;
    logic                   start_fetch;
    logic                   ack_taken;

    // Segment base is CS times 16
    assign phys_addr = {cs, 4'h0} + {4'h0, fetch_ip};

    // A redirect in the same cycle wins over a new fetch
    assign start_fetch = (state == pf_idle) && !redirect && !fifo_nearly_full;
    assign ack_taken = (state == pf_fetching) && instr_m_ack;

    assign instr_m_access = (state == pf_fetching) || (state == pf_discard);

    assign fifo_wr_en = (state == pf_write_low) || (state == pf_write_high);
    assign fifo_wr_data = (state == pf_write_high) ?
        fetched_word[`FETCH_WORD_W-1:`FETCH_BYTE_W] :
        fetched_word[`FETCH_BYTE_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= pf_idle;
            fetch_ip <= '0;
        end else begin
            case (state)
                pf_idle: begin
                    if (start_fetch)
                        state <= pf_fetching;
                end
                pf_fetching: begin
                    if (redirect)
                        state <= instr_m_ack ? pf_idle : pf_discard;
                    else if (instr_m_ack)
                        // Odd IP, so the low byte is not part of the stream
                        state <= fetch_ip[0] ? pf_write_high : pf_write_low;
                end
                pf_write_low: begin
                    state <= redirect ? pf_idle : pf_write_high;
                end
                pf_write_high: begin
                    state <= pf_idle;
                end
                pf_discard: begin
                    if (instr_m_ack)
                        state <= pf_idle;
                end
                default: begin
                    state <= pf_idle;
                end
            endcase

            if (redirect)
                fetch_ip <= redirect_ip;
            else if (state == pf_write_high)
                fetch_ip <= {fetch_ip[`FETCH_WORD_W-1:1] + 1'b1, 1'b0};
        end
    end

    // Address is held steady for the whole access
    always_ff @(posedge clk) begin
        if (start_fetch)
            instr_m_addr <= phys_addr[`FETCH_ADDR_W:1];
        if (ack_taken)
            fetched_word <= instr_m_data_in;
    end

endmodule

// ==== tb_fetch_frontend.sv ====
`timescale 1ns/100ps

module tb_fetch_frontend;
    import fetch_bus_pkg::*;
    import fetch_stream_pkg::*;

    localparam int          wait_limit = 64;
    localparam logic [16:0] lfsr_seed = 17'd79776;
    localparam logic [16:0] lfsr_taps = 17'h12000;

    logic        clk;
    logic        arst_n;
    fetch_word_t cs;
    logic        load_ip;
    fetch_word_t new_ip;
    logic        start_instruction;
    logic        rollback;
    fetch_word_t ip;
    word_addr_t  instr_m_addr;
    logic        instr_m_access;
    logic        instr_m_ack;
    bus_word_t   instr_m_data_in;
    logic        opcode_rd;
    fetch_byte_t opcode_byte;
    logic        stream_empty;
    logic        immed_start;
    logic        immed_is_8bit;
    fetch_word_t immediate;
    logic        immed_busy;
    logic        immed_complete;

    int          value_errors;
    int          timeouts;
    fetch_word_t exp_ip;
    logic [16:0] lfsr;
    logic        mem_pending;
    logic [1:0]  mem_delay;
    word_addr_t  req_addr;

    fetch_frontend dut_i (
        .clk               (clk),
        .arst_n            (arst_n),
        .cs                (cs),
        .load_ip           (load_ip),
        .new_ip            (new_ip),
        .start_instruction (start_instruction),
        .rollback          (rollback),
        .ip                (ip),
        .instr_m_addr      (instr_m_addr),
        .instr_m_access    (instr_m_access),
        .instr_m_ack       (instr_m_ack),
        .instr_m_data_in   (instr_m_data_in),
        .opcode_rd         (opcode_rd),
        .opcode_byte       (opcode_byte),
        .stream_empty      (stream_empty),
        .immed_start       (immed_start),
        .immed_is_8bit     (immed_is_8bit),
        .immediate         (immediate),
        .immed_busy        (immed_busy),
        .immed_complete    (immed_complete)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Folds all 20 address bits so a wrong segment or offset shows up
    function automatic fetch_byte_t model_byte(input logic [19:0] p);
        return p[7:0] ^ p[15:8] ^ {4'h0, p[19:16]} ^ 8'h5A;
    endfunction

    function automatic fetch_byte_t stream_byte(input fetch_word_t offset);
        logic [19:0] base;
        base = cs;
        return model_byte(base * 20'd16 + offset);
    endfunction

    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    task automatic report_value(input string test, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        value_errors++;
        $display("** Error %s: %s expected 0x%0h, actual 0x%0h", test, what, expected, actual);
    endtask

    task automatic report_timeout(input string test, input string what);
        timeouts++;
        $display("Timeout in %s: %s", test, what);
    endtask

    // Instruction memory that acks after 0 to 3 cycles
    initial begin
        instr_m_ack = 1'b0;
        instr_m_data_in = '0;
        lfsr = lfsr_seed;
        mem_pending = 1'b0;
        mem_delay = '0;
        req_addr = '0;
        forever begin
            @(negedge clk);
            instr_m_ack = 1'b0;
            if (instr_m_access && !mem_pending) begin
                mem_delay[0] = lfsr[0];
                lfsr = lfsr_step(lfsr);
                mem_delay[1] = lfsr[0];
                lfsr = lfsr_step(lfsr);
                mem_pending = 1'b1;
                req_addr = instr_m_addr;
            end
            if (mem_pending) begin
                // Access and address stay put until the ack
                if (instr_m_access !== 1'b1)
                    report_value("instr_bus", "instr_m_access before ack", 1,
                                 instr_m_access);
                if (instr_m_addr !== req_addr)
                    report_value("instr_bus", "instr_m_addr during access", req_addr,
                                 instr_m_addr);
                if (mem_delay == 2'd0) begin
                    instr_m_ack = 1'b1;
                    instr_m_data_in = {model_byte({instr_m_addr, 1'b1}),
                                       model_byte({instr_m_addr, 1'b0})};
                    mem_pending = 1'b0;
                end else begin
                    mem_delay = mem_delay - 1'b1;
                end
            end
        end
    end

    task automatic pop_byte(input string test, output fetch_byte_t got);
        int n;
        n = 0;
        got = '0;
        while (stream_empty && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (stream_empty) begin
            report_timeout(test, "the byte stream stayed empty");
            return;
        end
        opcode_rd = 1'b1;
        @(negedge clk);
        opcode_rd = 1'b0;
        got = opcode_byte;
        if (got !== stream_byte(exp_ip))
            report_value(test, "opcode_byte", stream_byte(exp_ip), got);
        exp_ip++;
        if (ip !== exp_ip)
            report_value(test, "ip after pop", exp_ip, ip);
    endtask

    task automatic read_immediate(input string test, input logic is_8bit);
        int          n;
        fetch_word_t expected;
        expected = is_8bit ? {8'h00, stream_byte(exp_ip)} :
                             {stream_byte(exp_ip + 16'd1), stream_byte(exp_ip)};
        immed_start = 1'b1;
        immed_is_8bit = is_8bit;
        @(negedge clk);
        immed_start = 1'b0;
        if (immed_busy !== 1'b1)
            report_value(test, "immed_busy", 1, immed_busy);
        n = 0;
        while (!immed_complete && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!immed_complete) begin
            report_timeout(test, "immed_complete never came");
            return;
        end
        if (immediate !== expected)
            report_value(test, "immediate", expected, immediate);
        exp_ip = exp_ip + (is_8bit ? 16'd1 : 16'd2);
        if (ip !== exp_ip)
            report_value(test, "ip after immediate", exp_ip, ip);
        @(negedge clk);
        // Exactly one complete pulse
        if (immed_complete !== 1'b0)
            report_value(test, "immed_complete one cycle later", 0, immed_complete);
        if (immed_busy !== 1'b0)
            report_value(test, "immed_busy after complete", 0, immed_busy);
    endtask

    // Load or rollback, then wait out the redirect and the flush
    task automatic apply_redirect(input string test, input logic by_rollback,
                                  input fetch_word_t target);
        if (by_rollback) begin
            rollback = 1'b1;
        end else begin
            new_ip = target;
            load_ip = 1'b1;
        end
        @(negedge clk);
        load_ip = 1'b0;
        rollback = 1'b0;
        @(negedge clk);
        exp_ip = target;
        if (ip !== target)
            report_value(test, "ip after redirect", target, ip);
        if (stream_empty !== 1'b1)
            report_value(test, "stream_empty after redirect", 1, stream_empty);
    endtask

    task automatic check_after_reset;
        if (instr_m_access !== 1'b0)
            report_value("check_after_reset", "instr_m_access", 0, instr_m_access);
        if (immed_busy !== 1'b0)
            report_value("check_after_reset", "immed_busy", 0, immed_busy);
        if (immed_complete !== 1'b0)
            report_value("check_after_reset", "immed_complete", 0, immed_complete);
        if (ip !== 16'h0000)
            report_value("check_after_reset", "ip", 0, ip);
    endtask

    task automatic pop_in_order;
        fetch_byte_t b;
        cs = 16'h1000;
        apply_redirect("pop_in_order", 1'b0, 16'h0010);
        repeat (12) pop_byte("pop_in_order", b);
    endtask

    task automatic read_immediates;
        read_immediate("read_immediates", 1'b0);
        read_immediate("read_immediates", 1'b1);
        read_immediate("read_immediates", 1'b0);
        read_immediate("read_immediates", 1'b1);
    endtask

    task automatic load_odd_ip;
        fetch_byte_t b;
        cs = 16'h0F21;
        apply_redirect("load_odd_ip", 1'b0, 16'h1233);
        repeat (5) pop_byte("load_odd_ip", b);
        read_immediate("load_odd_ip", 1'b0);
    endtask

    task automatic replay_after_rollback;
        fetch_byte_t first [7];
        fetch_byte_t b;
        fetch_word_t captured;
        captured = exp_ip;
        start_instruction = 1'b1;
        @(negedge clk);
        start_instruction = 1'b0;
        for (int i = 0; i < 7; i++)
            pop_byte("replay_after_rollback", first[i]);
        apply_redirect("replay_after_rollback", 1'b1, captured);
        for (int i = 0; i < 7; i++) begin
            pop_byte("replay_after_rollback", b);
            if (b !== first[i])
                report_value("replay_after_rollback", "replayed byte", first[i], b);
        end
    endtask

    task automatic run_mixed_stream;
        fetch_byte_t b;
        cs = 16'h0800;
        apply_redirect("run_mixed_stream", 1'b0, 16'h7FF9);
        for (int i = 0; i < 60; i++) begin
            case (i % 4)
                0, 2: pop_byte("run_mixed_stream", b);
                1: read_immediate("run_mixed_stream", 1'b0);
                default: read_immediate("run_mixed_stream", 1'b1);
            endcase
            // Idle gaps let the queue fill up
            if (i % 7 == 0)
                repeat (8) @(negedge clk);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        cs = '0;
        load_ip = 1'b0;
        new_ip = '0;
        start_instruction = 1'b0;
        rollback = 1'b0;
        opcode_rd = 1'b0;
        immed_start = 1'b0;
        immed_is_8bit = 1'b0;
        value_errors = 0;
        timeouts = 0;
        exp_ip = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        check_after_reset();
        pop_in_order();
        read_immediates();
        load_odd_ip();
        replay_after_rollback();
        run_mixed_stream();
        repeat (4) @(negedge clk);
        $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
